//--- files.f
common/afifo_pkg.sv
async_fifo/cdc_sync.sv
async_fifo/fifo_pointer.sv
async_fifo/fifo_memory.sv
async_fifo/fifo_side_ctrl.sv
async_fifo/asynchronous_fifo.sv
design/axi4s_async_fifo.sv
tests/axi4s_async_fifo_chk.sv
tests/tb_clock.sv
tests/tb_axi4s_async_fifo.sv

//--- Bender.yml
package:
  name: axi4s_async_fifo

sources:
  # RTL, in compile order
  - files:
      - common/afifo_pkg.sv
      - async_fifo/cdc_sync.sv
      - async_fifo/fifo_pointer.sv
      - async_fifo/fifo_memory.sv
      - async_fifo/fifo_side_ctrl.sv
      - async_fifo/asynchronous_fifo.sv
      - design/axi4s_async_fifo.sv

  # Testbench, checker and clock generator
  - target: test
    files:
      - tests/axi4s_async_fifo_chk.sv
      - tests/tb_clock.sv
      - tests/tb_axi4s_async_fifo.sv

//--- tests/tb_axi4s_async_fifo.sv
// Directed testbench for the AXI4-Stream dual-clock FIFO
// Runs five tests in sequence and keeps a scoreboard of accepted words
`timescale 1ns/1ps
`default_nettype none

module tb_axi4s_async_fifo import afifo_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 200;

  logic                   clk_wp;
  logic                   clk_rp;
  logic                   power_on_reset;
  logic                   flush_reset;
  logic                   reset;
  logic [TUSER_WIDTH-1:0] wp_axi4s_tuser;
  logic                   wp_axi4s_tvalid;
  logic                   wp_axi4s_tready;
  logic [ADDRESS_WIDTH:0] sr_wp_fill_level;
  logic                   rp_axi4s_tready;
  logic [TUSER_WIDTH-1:0] rp_axi4s_tuser;
  logic                   rp_axi4s_tvalid;
  logic [31:0]            lcg_state = 32'h55b6ac9a;
  // Words accepted on the write side and not yet seen on the read side
  logic [TUSER_WIDTH-1:0] sent_words [$];

  tb_clock i_tb_clock (
    .clk_wp (clk_wp),
    .clk_rp (clk_rp),
    .reset  (power_on_reset)
  );

  // The flush test adds its own reset pulse on top of the power-on one
  assign reset = power_on_reset || flush_reset;

  axi4s_async_fifo i_axi4s_async_fifo (
    .clk_wp           (clk_wp),
    .reset            (reset),
    .wp_axi4s_tuser   (wp_axi4s_tuser),
    .wp_axi4s_tvalid  (wp_axi4s_tvalid),
    .wp_axi4s_tready  (wp_axi4s_tready),
    .sr_wp_fill_level (sr_wp_fill_level),
    .clk_rp           (clk_rp),
    .rp_axi4s_tready  (rp_axi4s_tready),
    .rp_axi4s_tuser   (rp_axi4s_tuser),
    .rp_axi4s_tvalid  (rp_axi4s_tvalid)
  );

  bind axi4s_async_fifo axi4s_async_fifo_chk i_axi4s_async_fifo_chk (
    .clk_wp           (clk_wp),
    .clk_rp           (clk_rp),
    .reset            (reset),
    .wp_axi4s_tready  (wp_axi4s_tready),
    .sr_wp_fill_level (sr_wp_fill_level),
    .rp_axi4s_tvalid  (rp_axi4s_tvalid),
    .rp_axi4s_tready  (rp_axi4s_tready),
    .rp_axi4s_tuser   (rp_axi4s_tuser)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Low bits of this generator repeat quickly, so callers use the upper bits
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("Error in %s: expected %0h, actual %0h",
                          test_name, expected, actual));
    end
  endtask

  // Outputs are sampled on the falling edge, half a period away from any update
  task automatic wait_write_ready(input string test_name);
    int cycles;
    cycles = 0;
    @(negedge clk_wp);
    while (!wp_axi4s_tready && cycles <= TIMEOUT_CYCLES) begin
      cycles++;
      @(negedge clk_wp);
    end
    if (!wp_axi4s_tready) begin
      abort_run($sformatf("%s: the write side never became ready", test_name));
    end
  endtask

  task automatic wait_fill_zero(input string test_name);
    int cycles;
    cycles = 0;
    @(negedge clk_wp);
    while (sr_wp_fill_level != 0 && cycles <= TIMEOUT_CYCLES) begin
      cycles++;
      @(negedge clk_wp);
    end
    if (sr_wp_fill_level != 0) begin
      abort_run($sformatf("%s: the fill level never returned to zero", test_name));
    end
  endtask

  // Valid stays up with the same word until it is accepted
  task automatic send_words(input int count, input bit random_gaps, input string test_name);
    int          sent;
    int          stall;
    logic [31:0] random_word;
    sent  = 0;
    stall = 0;
    @(posedge clk_wp);
    #1;
    while (sent < count && stall <= TIMEOUT_CYCLES) begin
      if (!wp_axi4s_tvalid) begin
        random_word     = lcg_next();
        wp_axi4s_tuser  = random_word[23:16];
        wp_axi4s_tvalid = random_gaps ? random_word[28] : 1'b1;
      end
      @(negedge clk_wp);
      if (wp_axi4s_tvalid && wp_axi4s_tready) begin
        // The word is taken at the coming rising edge
        sent_words.push_back(wp_axi4s_tuser);
        sent++;
        stall = 0;
        @(posedge clk_wp);
        #1;
        wp_axi4s_tvalid = 1'b0;
      end else begin
        stall++;
        @(posedge clk_wp);
        #1;
      end
    end
    wp_axi4s_tvalid = 1'b0;
    if (sent < count) begin
      abort_run($sformatf("%s: timed out waiting for the FIFO to accept a word", test_name));
    end
  endtask

  // Every word read is compared with the oldest word in the scoreboard
  task automatic receive_words(input int count, input bit random_ready,
                               input string test_name);
    int                     received;
    int                     stall;
    logic [31:0]            random_word;
    logic [TUSER_WIDTH-1:0] expected;
    received = 0;
    stall    = 0;
    @(posedge clk_rp);
    #1;
    while (received < count && stall <= TIMEOUT_CYCLES) begin
      if (random_ready) begin
        random_word     = lcg_next();
        rp_axi4s_tready = random_word[27];
      end else begin
        rp_axi4s_tready = 1'b1;
      end
      @(negedge clk_rp);
      if (rp_axi4s_tvalid && rp_axi4s_tready) begin
        if (sent_words.size() == 0) begin
          abort_run($sformatf("%s: a word came out that was never written", test_name));
        end else begin
          expected = sent_words.pop_front();
          check_value(test_name, expected, rp_axi4s_tuser);
          received++;
          stall = 0;
        end
      end else begin
        stall++;
      end
      @(posedge clk_rp);
      #1;
    end
    rp_axi4s_tready = 1'b0;
    if (received < count) begin
      abort_run($sformatf("%s: timed out waiting for read data", test_name));
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset_state();
    int cycles;
    cycles = 0;
    // Sample in the middle of the first clock cycle under reset
    @(posedge clk_wp);
    @(negedge clk_wp);
    check_value("test_reset_state", 0, wp_axi4s_tready);
    check_value("test_reset_state", 0, rp_axi4s_tvalid);
    check_value("test_reset_state", 0, sr_wp_fill_level);
    while (reset && cycles <= TIMEOUT_CYCLES) begin
      cycles++;
      @(negedge clk_wp);
    end
    if (reset) begin
      abort_run("test_reset_state: reset was never released");
    end
    wait_write_ready("test_reset_state");
  endtask

  task automatic test_ordered_transfer();
    fork
      send_words(40, 1'b0, "test_ordered_transfer");
      receive_words(40, 1'b0, "test_ordered_transfer");
    join
    check_value("test_ordered_transfer", 0, sent_words.size());
    // No extra word may follow the last one written
    @(negedge clk_rp);
    check_value("test_ordered_transfer", 0, rp_axi4s_tvalid);
    wait_fill_zero("test_ordered_transfer");
  endtask

  task automatic test_full_back_pressure();
    logic [31:0] random_word;
    send_words(FIFO_DEPTH, 1'b0, "test_full_back_pressure");
    // One more word is offered and must be refused while the sink stalls
    random_word     = lcg_next();
    wp_axi4s_tuser  = random_word[23:16];
    wp_axi4s_tvalid = 1'b1;
    for (int i = 0; i < 12; i++) begin
      @(negedge clk_wp);
      check_value("test_full_back_pressure", 0, wp_axi4s_tready);
      @(posedge clk_wp);
      #1;
    end
    wp_axi4s_tvalid = 1'b0;
    @(negedge clk_wp);
    check_value("test_full_back_pressure", FIFO_DEPTH, sr_wp_fill_level);
    @(negedge clk_rp);
    check_value("test_full_back_pressure", 1, rp_axi4s_tvalid);
    receive_words(FIFO_DEPTH, 1'b0, "test_full_back_pressure");
    check_value("test_full_back_pressure", 0, sent_words.size());
    @(negedge clk_rp);
    check_value("test_full_back_pressure", 0, rp_axi4s_tvalid);
    wait_fill_zero("test_full_back_pressure");
  endtask

  task automatic test_random_ready();
    fork
      send_words(100, 1'b1, "test_random_ready");
      receive_words(100, 1'b1, "test_random_ready");
    join
    check_value("test_random_ready", 0, sent_words.size());
    @(negedge clk_rp);
    check_value("test_random_ready", 0, rp_axi4s_tvalid);
    wait_fill_zero("test_random_ready");
  endtask

  task automatic test_reset_flush();
    send_words(5, 1'b0, "test_reset_flush");
    flush_reset = 1'b1;
    repeat (2) @(posedge clk_wp);
    #1;
    flush_reset = 1'b0;
    // The five stored words are gone
    sent_words.delete();
    @(negedge clk_wp);
    check_value("test_reset_flush", 0, sr_wp_fill_level);
    @(negedge clk_rp);
    check_value("test_reset_flush", 0, rp_axi4s_tvalid);
    wait_write_ready("test_reset_flush");
    send_words(1, 1'b0, "test_reset_flush");
    receive_words(1, 1'b0, "test_reset_flush");
    check_value("test_reset_flush", 0, sent_words.size());
    @(negedge clk_rp);
    check_value("test_reset_flush", 0, rp_axi4s_tvalid);
  endtask

  initial begin
    flush_reset     = 1'b0;
    wp_axi4s_tuser  = '0;
    wp_axi4s_tvalid = 1'b0;
    rp_axi4s_tready = 1'b0;
    test_reset_state();
    test_ordered_transfer();
    test_full_back_pressure();
    test_random_ready();
    test_reset_flush();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
// Clock and power-on reset for the FIFO testbench
// clk_wp runs at 10 ns and clk_rp at 16 ns, so their rising edges never coincide
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk_wp,
  output logic clk_rp,
  output logic reset
);

  initial begin
    clk_wp = 1'b0;
    forever #5 clk_wp = ~clk_wp;
  end

  initial begin
    clk_rp = 1'b0;
    forever #8 clk_rp = ~clk_rp;
  end

  // Held for two write clock cycles, released just after a rising edge
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk_wp);
    #1;
    reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- tests/axi4s_async_fifo_chk.sv
// Concurrent assertions on the ports of the AXI4-Stream FIFO
// Attached to the top level by a bind statement in the testbench
`timescale 1ns/1ps
`default_nettype none

module axi4s_async_fifo_chk import afifo_pkg::*; (
  input logic                   clk_wp,
  input logic                   clk_rp,
  input logic                   reset,
  input logic                   wp_axi4s_tready,
  input logic [ADDRESS_WIDTH:0] sr_wp_fill_level,
  input logic                   rp_axi4s_tvalid,
  input logic                   rp_axi4s_tready,
  input logic [TUSER_WIDTH-1:0] rp_axi4s_tuser
);

  // A stalled output word must hold until the sink takes it
  read_data_stable: assert property (
    @(posedge clk_rp) disable iff (reset)
    rp_axi4s_tvalid && !rp_axi4s_tready |=> $stable(rp_axi4s_tuser)
  ) else $error("rp_axi4s_tuser changed while the read side was stalled");

  // Reset is synchronous, so tready drops from the edge after reset is seen
  ready_low_in_reset: assert property (
    @(posedge clk_wp) reset |=> !wp_axi4s_tready
  ) else $error("wp_axi4s_tready was high after reset was applied");

  // The write side can over-report, but never beyond the storage size
  fill_level_limit: assert property (
    @(posedge clk_wp) disable iff (reset)
    sr_wp_fill_level <= FIFO_DEPTH
  ) else $error("sr_wp_fill_level went above the FIFO depth");

endmodule

`default_nettype wire

//--- design/axi4s_async_fifo.sv
// AXI4-Stream TUSER buffer crossing from clk_wp to clk_rp
// Maps the valid/ready handshake of both sides onto the dual-clock FIFO
`timescale 1ns/1ps
`default_nettype none

module axi4s_async_fifo import afifo_pkg::*; (
  input  logic                   clk_wp,
  input  logic                   reset,
  input  logic [TUSER_WIDTH-1:0] wp_axi4s_tuser,
  input  logic                   wp_axi4s_tvalid,
  output logic                   wp_axi4s_tready,
  output logic [ADDRESS_WIDTH:0] sr_wp_fill_level,

  input  logic                   clk_rp,
  input  logic                   rp_axi4s_tready,
  output logic [TUSER_WIDTH-1:0] rp_axi4s_tuser,
  output logic                   rp_axi4s_tvalid
);

  logic wp_fifo_full;
  logic rp_fifo_empty;
  logic sr_wp_fifo_active;
  logic sr_rp_fifo_active;
  logic wp_axi4s_transaction;
  logic rp_axi4s_transaction;

  // Each side only takes part in the handshake once start-up is done
  assign wp_axi4s_tready = !wp_fifo_full && sr_wp_fifo_active;
  assign rp_axi4s_tvalid = !rp_fifo_empty && sr_rp_fifo_active;

  // A word moves on an edge where valid and ready are both high
  assign wp_axi4s_transaction = wp_axi4s_tvalid && wp_axi4s_tready;
  assign rp_axi4s_transaction = rp_axi4s_tvalid && rp_axi4s_tready;

  // The read data follows the read pointer, so it holds still while the
  // sink stalls with tready low
  asynchronous_fifo i_asynchronous_fifo (
    .clk_wp         (clk_wp),
    .reset          (reset),
    .clk_rp         (clk_rp),
    .write_en       (wp_axi4s_transaction),
    .write_data     (wp_axi4s_tuser),
    .fifo_full      (wp_fifo_full),
    .read_en        (rp_axi4s_transaction),
    .read_data      (rp_axi4s_tuser),
    .fifo_empty     (rp_fifo_empty),
    .wp_fifo_active (sr_wp_fifo_active),
    .rp_fifo_active (sr_rp_fifo_active),
    .wp_fill_level  (sr_wp_fill_level)
  );

endmodule

`default_nettype wire

//--- async_fifo/asynchronous_fifo.sv
// Dual-clock FIFO with Gray pointers, synchronizers and a two-port memory
// Owns the whole crossing, including the read-domain copy of the reset
`timescale 1ns/1ps
`default_nettype none

module asynchronous_fifo import afifo_pkg::*; (
  input  logic                   clk_wp,
  input  logic                   reset,
  input  logic                   clk_rp,
  input  logic                   write_en,
  input  logic [TUSER_WIDTH-1:0] write_data,
  output logic                   fifo_full,
  input  logic                   read_en,
  output logic [TUSER_WIDTH-1:0] read_data,
  output logic                   fifo_empty,
  output logic                   wp_fifo_active,
  output logic                   rp_fifo_active,
  output logic [ADDRESS_WIDTH:0] wp_fill_level
);

  logic                     rp_run;
  logic                     rp_reset;
  logic [ADDRESS_WIDTH-1:0] wp_address;
  logic [ADDRESS_WIDTH-1:0] rp_address;
  logic [ADDRESS_WIDTH:0]   wp_gray;
  logic [ADDRESS_WIDTH:0]   rp_gray;
  logic [ADDRESS_WIDTH:0]   wp_gray_in_rp;
  logic [ADDRESS_WIDTH:0]   rp_gray_in_wp;
  logic [ADDRESS_WIDTH:0]   wp_pointer_fill;
  logic                     wp_own_ready;
  logic                     rp_own_ready;
  logic                     wp_peer_ready;
  logic                     rp_peer_ready;

  //////////////////////////////
  // Read-domain reset
  //////////////////////////////

  // A run flag is shifted in on clk_rp once reset is low
  // Assertion reaches the read side at once, release waits for the chain
  cdc_sync #(
    .width    (1)
  ) i_reset_sync (
    .clk      (clk_rp),
    .reset    (reset),
    .async_in (1'b1),
    .sync_out (rp_run)
  );

  assign rp_reset = reset || !rp_run;

  //////////////////////////////
  // Write side
  //////////////////////////////

  fifo_pointer i_wp_pointer (
    .clk           (clk_wp),
    .reset         (reset),
    .side_is_write (1'b1),
    .advance       (write_en),
    .peer_gray     (rp_gray_in_wp),
    .address       (wp_address),
    .gray          (wp_gray),
    .limit_reached (fifo_full),
    .fill_level    (wp_pointer_fill)
  );

  cdc_sync #(
    .width    (ADDRESS_WIDTH + 1)
  ) i_rp_gray_sync (
    .clk      (clk_wp),
    .reset    (reset),
    .async_in (rp_gray),
    .sync_out (rp_gray_in_wp)
  );

  // This chain keeps sampling through reset, so the write side waits
  // until the read side has really dropped its ready flag
  cdc_sync #(
    .width    (1)
  ) i_rp_ready_sync (
    .clk      (clk_wp),
    .reset    (1'b0),
    .async_in (rp_own_ready),
    .sync_out (wp_peer_ready)
  );

  fifo_side_ctrl i_wp_side_ctrl (
    .clk         (clk_wp),
    .reset       (reset),
    .peer_ready  (wp_peer_ready),
    .own_ready   (wp_own_ready),
    .fifo_active (wp_fifo_active)
  );

  // Until start-up ends the synchronized read pointer may still be stale
  assign wp_fill_level = wp_fifo_active ? wp_pointer_fill : '0;

  //////////////////////////////
  // Storage
  //////////////////////////////

  fifo_memory i_fifo_memory (
    .clk_wp        (clk_wp),
    .write_en      (write_en),
    .write_address (wp_address),
    .write_data    (write_data),
    .read_address  (rp_address),
    .read_data     (read_data)
  );

  //////////////////////////////
  // Read side
  //////////////////////////////

  fifo_pointer i_rp_pointer (
    .clk           (clk_rp),
    .reset         (rp_reset),
    .side_is_write (1'b0),
    .advance       (read_en),
    .peer_gray     (wp_gray_in_rp),
    .address       (rp_address),
    .gray          (rp_gray),
    .limit_reached (fifo_empty),
    .fill_level    ()
  );

  cdc_sync #(
    .width    (ADDRESS_WIDTH + 1)
  ) i_wp_gray_sync (
    .clk      (clk_rp),
    .reset    (rp_reset),
    .async_in (wp_gray),
    .sync_out (wp_gray_in_rp)
  );

  // Cleared by the read reset, so the read side leaves side_reset
  // straight after release and then waits for the write side
  cdc_sync #(
    .width    (1)
  ) i_wp_ready_sync (
    .clk      (clk_rp),
    .reset    (rp_reset),
    .async_in (wp_own_ready),
    .sync_out (rp_peer_ready)
  );

  fifo_side_ctrl i_rp_side_ctrl (
    .clk         (clk_rp),
    .reset       (rp_reset),
    .peer_ready  (rp_peer_ready),
    .own_ready   (rp_own_ready),
    .fifo_active (rp_fifo_active)
  );

endmodule

`default_nettype wire

//--- async_fifo/fifo_side_ctrl.sv
// Start-up controller for one side of the dual-clock FIFO
// Keeps the side inactive until the other clock domain is out of reset
`timescale 1ns/1ps
`default_nettype none

module fifo_side_ctrl import afifo_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic peer_ready,
  output logic own_ready,
  output logic fifo_active
);

  side_state_t state;
  side_state_t state_next;

  //////////////////////////////
  // State sequence
  //////////////////////////////

  // The side leaves side_reset only once the peer is seen not ready
  // That way a short reset of one domain is always noticed by the other,
  // and a stale ready level from before the reset is never trusted
  always_comb begin
    state_next = state;
    unique case (state)
      side_reset: begin
        if (!peer_ready) begin
          state_next = side_wait_peer;
        end
      end
      side_wait_peer: begin
        if (peer_ready) begin
          state_next = side_active;
        end
      end
      side_active: begin
        // The peer went back into reset, so transfers must stop
        if (!peer_ready) begin
          state_next = side_wait_peer;
        end
      end
      default: begin
        state_next = side_reset;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= side_reset;
    end else begin
      state <= state_next;
    end
  end

  // Registered state only, so both flags are glitch-free for the crossing
  assign own_ready   = (state != side_reset);
  assign fifo_active = (state == side_active);

endmodule

`default_nettype wire

//--- async_fifo/fifo_memory.sv
// Two-port storage of the FIFO, written on the write clock
// Read asynchronously, so the output follows the read pointer directly
`timescale 1ns/1ps
`default_nettype none

module fifo_memory import afifo_pkg::*; (
  input  logic                     clk_wp,
  input  logic                     write_en,
  input  logic [ADDRESS_WIDTH-1:0] write_address,
  input  logic [TUSER_WIDTH-1:0]   write_data,
  input  logic [ADDRESS_WIDTH-1:0] read_address,
  output logic [TUSER_WIDTH-1:0]   read_data
);

  logic [TUSER_WIDTH-1:0] storage [FIFO_DEPTH];

  // The pointer logic only enables a write into a free entry
  always_ff @(posedge clk_wp) begin
    if (write_en) begin
      storage[write_address] <= write_data;
    end
  end

  // An entry is stable by the time the read side sees it as filled,
  // since the write pointer reaches the read clock through a synchronizer
  assign read_data = storage[read_address];

endmodule

`default_nettype wire

//--- async_fifo/fifo_pointer.sv
// Binary and Gray pointer for one FIFO side, with the full or empty flag
// One instance runs on the write clock and one on the read clock
`timescale 1ns/1ps
`default_nettype none

module fifo_pointer import afifo_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   side_is_write,
  input  logic                   advance,
  input  logic [ADDRESS_WIDTH:0] peer_gray,
  output logic [ADDRESS_WIDTH-1:0] address,
  output logic [ADDRESS_WIDTH:0] gray,
  output logic                   limit_reached,
  output logic [ADDRESS_WIDTH:0] fill_level
);

  logic [ADDRESS_WIDTH:0] binary_q;
  logic [ADDRESS_WIDTH:0] binary_next;
  logic [ADDRESS_WIDTH:0] peer_binary;
  logic                   step;

  //////////////////////////////
  // Own pointer
  //////////////////////////////

  // Never step past full or empty, even if the enable is wrong
  assign step        = advance && !limit_reached;
  assign binary_next = binary_q + {{ADDRESS_WIDTH{1'b0}}, step};

  // The Gray copy is registered so the crossing sees a glitch-free bus
  always_ff @(posedge clk) begin
    if (reset) begin
      binary_q <= '0;
      gray     <= '0;
    end else begin
      binary_q <= binary_next;
      gray     <= binary_next ^ (binary_next >> 1);
    end
  end

  // The wrap bit is dropped for the memory address
  assign address = binary_q[ADDRESS_WIDTH-1:0];

  //////////////////////////////
  // Peer pointer and flags
  //////////////////////////////

  // Each binary bit of the peer pointer is the XOR of all Gray bits at and above it
  always_comb begin
    peer_binary[ADDRESS_WIDTH] = peer_gray[ADDRESS_WIDTH];
    for (int i = ADDRESS_WIDTH - 1; i >= 0; i--) begin
      peer_binary[i] = peer_binary[i+1] ^ peer_gray[i];
    end
  end

  // Full when the write pointer is one lap ahead of the read pointer
  // Empty when both pointers are identical
  always_comb begin
    if (side_is_write) begin
      limit_reached = (binary_q[ADDRESS_WIDTH] != peer_binary[ADDRESS_WIDTH]) &&
                      (binary_q[ADDRESS_WIDTH-1:0] == peer_binary[ADDRESS_WIDTH-1:0]);
    end else begin
      limit_reached = (binary_q == peer_binary);
    end
  end

  // Words held, seen from this side
  // The peer pointer lags, so the write side can only over-report
  assign fill_level = side_is_write ? (binary_q - peer_binary)
                                    : (peer_binary - binary_q);

endmodule

`default_nettype wire

//--- async_fifo/cdc_sync.sv
// Multi-flop synchronizer for Gray-coded buses and slow levels
// Instantiated in the destination clock domain of each crossing
`timescale 1ns/1ps
`default_nettype none

module cdc_sync import afifo_pkg::*; #(
  parameter int width = 1
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [width-1:0] async_in,
  output logic [width-1:0] sync_out
);

  // Stage 0 may go metastable, the later stages give it time to settle
  logic [width-1:0] sync_stages [SYNC_STAGES];

  // A multi-bit capture is only safe because at most one bit changes
  // between two source edges, as for a Gray pointer
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_stages[i] <= '0;
      end
    end else begin
      sync_stages[0] <= async_in;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_stages[i] <= sync_stages[i-1];
      end
    end
  end

  assign sync_out = sync_stages[SYNC_STAGES-1];

endmodule

`default_nettype wire

//--- common/afifo_pkg.sv
// Sizes and types shared by the dual-clock AXI4-Stream FIFO
// Every FIFO module pulls these in with a wildcard import in its header
package afifo_pkg;

  //////////////////////////////
  // Data and storage sizes
  //////////////////////////////

  // Width of the TUSER word carried across the clock crossing
  localparam int TUSER_WIDTH = 8;

  // Memory address bits; the pointers carry one extra wrap bit on top
  localparam int ADDRESS_WIDTH = 4;

  // Number of storage entries
  localparam int FIFO_DEPTH = 2 ** ADDRESS_WIDTH;

  // Flip-flops in each synchronizer chain
  // Two is the minimum for a safe capture of an asynchronous level
  localparam int SYNC_STAGES = 2;

  //////////////////////////////
  // Side controller states
  //////////////////////////////

  // Start-up sequence of one FIFO side
  // A side moves to side_active only after the other clock domain has
  // reported that it is out of reset
  typedef enum logic [1:0] {
    side_reset     = 2'd0,
    side_wait_peer = 2'd1,
    side_active    = 2'd2
  } side_state_t;

endpackage
